//--- hdl/arithPkg.sv
package arithPkg;

	// Operation codes written to the control register
	typedef enum logic [1:0] {
		opAdd = 2'd0,  // A + B
		opSub = 2'd1,  // A + ~B + 1
		opAdc = 2'd2   // A + B + stored carry
		// Code 3 is decoded as opAdd
	} opcodeT;

	// Word addresses of the register block
	typedef enum logic [2:0] {
		regOpA    = 3'd0,  // Read/write
		regOpB    = 3'd1,  // Read/write
		regCtrl   = 3'd2,  // Write starts an operation
		regResult = 3'd3,  // Read only
		regFlags  = 3'd4   // Read only
	} regAddrT;

	// Bit positions inside the flags register
	localparam int flagZero     = 0;
	localparam int flagCarry    = 1;
	localparam int flagOverflow = 2;
	localparam int flagNegative = 3;  // Highest used bit

endpackage

//--- hdl/aluIf.sv
interface aluIf #(
	parameter int width = 32  // Operand width
);

	// Register block to datapath
	logic [width-1:0] opA;
	logic [width-1:0] opB;
	arithPkg::opcodeT op;
	logic             carryIn;  // Stored carry flag

	// Datapath results
	logic [width-1:0] sum;
	logic             carryOut;
	logic             overflow;
	logic             negative;
	logic             zero;

	modport regs (
		output opA, opB, op, carryIn,
		input  sum, carryOut, overflow, negative, zero
	);

	modport alu (
		input  opA, opB, op, carryIn,
		output sum, carryOut, overflow, negative, zero
	);

endinterface

//--- hdl/SumZeroDet.sv
// Zero test on A + B + carryIn without waiting for the carry chain.
// A zero sum forces the carry into bit i to equal a[i-1] | b[i-1],
// so each bit can be checked locally against its neighbour below.
module SumZeroDet #(
	parameter int width = 32  // Operand width
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	input  logic             carryIn,
	output logic             zero      // High when the sum wraps to all zeroes
);

	logic [width-1:0] bitZero;  // Per-bit zero terms
	logic             allZero;

	always_comb begin
		bitZero[0] = ~((a[0] ^ b[0]) ^ carryIn);  // Real carry at bit 0
		for (int i = 1; i < width; i++) begin
			// Implied carry from the pair below
			bitZero[i] = ~((a[i] ^ b[i]) ^ (a[i-1] | b[i-1]));
		end
	end

	// Reduction AND over all terms
	always_comb begin
		allZero = bitZero[0];
		for (int i = 1; i < width; i++) begin
			allZero &= bitZero[i];
		end
	end

	assign zero = allZero;

endmodule

//--- hdl/AddSub.sv
// Combinational add/subtract datapath.
// Results follow the register block inputs with no clocking.
module AddSub #(
	parameter int width = 32  // Operand width
) (
	aluIf.alu alu
);

	logic [width-1:0] opBEff;   // B after opcode decode
	logic             carryEff; // Carry-in after opcode decode
	logic [width:0]   fullSum;  // Extra top bit holds carry out
	logic             zeroDet;

	// Opcode decode
	always_comb begin
		case (alu.op)
			arithPkg::opSub: begin
				opBEff   = ~alu.opB;     // Two's complement via inverted B
				carryEff = 1'b1;         // plus one
			end
			arithPkg::opAdc: begin
				opBEff   = alu.opB;
				carryEff = alu.carryIn;  // Chained carry from last op
			end
			default: begin           // opAdd and the unused code
				opBEff   = alu.opB;
				carryEff = 1'b0;
			end
		endcase
	end

	// Single wide add, carry out falls into the top bit
	assign fullSum = {1'b0, alu.opA} + {1'b0, opBEff} + {{width{1'b0}}, carryEff};

	assign alu.sum      = fullSum[width-1:0];
	assign alu.carryOut = fullSum[width];
	assign alu.negative = fullSum[width-1];

	// Signed overflow
	// Operands agree in sign but the sum does not
	assign alu.overflow = (alu.opA[width-1] == opBEff[width-1]) &&
		(fullSum[width-1] != alu.opA[width-1]);

	// Zero flag from the operands, not from the finished sum
	SumZeroDet #(
		.width(width)
	) sumZero (
		.a      (alu.opA),
		.b      (opBEff),
		.carryIn(carryEff),
		.zero   (zeroDet)
	);

	assign alu.zero = zeroDet;

endmodule

//--- hdl/ArithRegs.sv
// Wishbone classic slave holding operands, opcode, result and flags.
// Ack is registered, one cycle wide, and never back to back.
module ArithRegs #(
	parameter int width = 32  // Bus and operand width
) (
	input  logic             clk,
	input  logic             arstN,
	input  logic             wbCyc,
	input  logic             wbStb,
	input  logic             wbWe,
	input  logic [2:0]       wbAdr,
	input  logic [width-1:0] wbDatW,
	output logic [width-1:0] wbDatR,
	output logic             wbAck,
	aluIf.regs               alu
);

	logic                              req;      // Valid bus cycle
	logic                              wrEn;     // Write commits this edge
	logic                              ctrlWr;   // Write to control register
	arithPkg::regAddrT                 addr;
	arithPkg::opcodeT                  newOp;    // Opcode on the bus data
	logic [width-1:0]                  opAReg;
	logic [width-1:0]                  opBReg;
	arithPkg::opcodeT                  opReg;    // Last opcode written
	logic [width-1:0]                  resultReg;
	logic [arithPkg::flagNegative:0]   flagsReg;

	assign req    = wbCyc & wbStb;
	assign addr   = arithPkg::regAddrT'(wbAdr);
	assign wrEn   = req & wbWe & wbAck;  // Commit on the ack cycle
	assign ctrlWr = wrEn && (addr == arithPkg::regCtrl);
	assign newOp  = arithPkg::opcodeT'(wbDatW[1:0]);

	// Ack one clock after request, then forced low for a cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbAck <= 1'b0;
		end else begin
			wbAck <= req & ~wbAck;
		end
	end

	// Operand and opcode registers
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			opAReg <= '0;
			opBReg <= '0;
			opReg  <= arithPkg::opAdd;
		end else if (wrEn) begin
			case (addr)
				arithPkg::regOpA: opAReg <= wbDatW;
				arithPkg::regOpB: opBReg <= wbDatW;
				arithPkg::regCtrl: opReg <= newOp;
				default: ;  // Result, flags and holes are read only
			endcase
		end
	end

	// Results captured in the same edge as the opcode
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resultReg <= '0;
			flagsReg  <= '0;  // Clears stored carry too
		end else if (ctrlWr) begin
			resultReg                        <= alu.sum;
			flagsReg[arithPkg::flagZero]     <= alu.zero;
			flagsReg[arithPkg::flagCarry]    <= alu.carryOut;
			flagsReg[arithPkg::flagOverflow] <= alu.overflow;
			flagsReg[arithPkg::flagNegative] <= alu.negative;
		end
	end

	// Datapath inputs
	assign alu.opA     = opAReg;
	assign alu.opB     = opBReg;
	assign alu.op      = ctrlWr ? newOp : opReg;  // Bypass so capture sees new op
	assign alu.carryIn = flagsReg[arithPkg::flagCarry];

	// Read mux
	always_comb begin
		case (addr)
			arithPkg::regOpA:    wbDatR = opAReg;
			arithPkg::regOpB:    wbDatR = opBReg;
			arithPkg::regCtrl:   wbDatR = {{(width-2){1'b0}}, opReg};
			arithPkg::regResult: wbDatR = resultReg;
			arithPkg::regFlags:
				wbDatR = {{(width-arithPkg::flagNegative-1){1'b0}}, flagsReg};
			default:             wbDatR = '0;  // Unmapped
		endcase
	end

endmodule

//--- hdl/ArithTop.sv
// Arithmetic unit top level with a plain Wishbone classic port
module ArithTop #(
	parameter int width = 32  // Bus and operand width
) (
	input  logic             clk,
	input  logic             arstN,
	input  logic             wbCyc,
	input  logic             wbStb,
	input  logic             wbWe,
	input  logic [2:0]       wbAdr,   // Word address
	input  logic [width-1:0] wbDatW,
	output logic [width-1:0] wbDatR,
	output logic             wbAck
);

	// Registers to datapath
	aluIf #(
		.width(width)
	) alu ();

	ArithRegs #(
		.width(width)
	) arithRegs (
		.clk   (clk),
		.arstN (arstN),
		.wbCyc (wbCyc),
		.wbStb (wbStb),
		.wbWe  (wbWe),
		.wbAdr (wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck (wbAck),
		.alu   (alu.regs)
	);

	AddSub #(
		.width(width)
	) addSub (
		.alu(alu.alu)
	);

endmodule

//--- dv/ArithTb.sv
module ArithTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int width      = 32;
	localparam int ackTimeout = 20;   // Cycles before a bus wait gives up
	localparam int numOps     = 300;

	logic             clk;
	logic             arstN;
	logic             wbCyc;
	logic             wbStb;
	logic             wbWe;
	logic [2:0]       wbAdr;
	logic [width-1:0] wbDatW;
	logic [width-1:0] wbDatR;
	logic             wbAck;

	// Reference model state
	logic [width-1:0] mA;
	logic [width-1:0] mB;
	logic [1:0]       mOp;
	logic [width-1:0] mRes;
	logic [width-1:0] mFlags;   // Stored carry lives in here

	ArithTop #(
		.width(width)
	) dut (
		.clk   (clk),
		.arstN (arstN),
		.wbCyc (wbCyc),
		.wbStb (wbStb),
		.wbWe  (wbWe),
		.wbAdr (wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck (wbAck)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;   // 100 ns period
	end

	// Expected {flags, result} for one operation
	function automatic logic [width+3:0] modelOp(input logic [1:0] op,
			input logic [width-1:0] a, input logic [width-1:0] b, input logic carry);
		logic [width-1:0] bEff;
		logic             cIn;
		logic [width:0]   uSum;
		longint           sSum;     // Exact signed sum, never wraps
		logic [3:0]       fl;
		bEff = b;
		cIn  = 1'b0;
		if (op == arithPkg::opSub) begin
			bEff = ~b;
			cIn  = 1'b1;
		end else if (op == arithPkg::opAdc) begin
			cIn = carry;
		end
		uSum = {1'b0, a} + {1'b0, bEff} + (width+1)'(cIn);
		sSum = longint'($signed(a)) + longint'($signed(bEff)) + longint'(cIn);
		fl[arithPkg::flagZero]     = (uSum[width-1:0] == '0);
		fl[arithPkg::flagCarry]    = uSum[width];
		// Signed result does not fit in width bits
		fl[arithPkg::flagOverflow] = (sSum != longint'($signed(uSum[width-1:0])));
		fl[arithPkg::flagNegative] = uSum[width-1];
		return {fl, uSum[width-1:0]};
	endfunction

	task automatic checkValue(input string name, input logic [width-1:0] exp,
			input logic [width-1:0] act);
		assert (act === exp) else begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			$display("*** TEST FAILED ***");
			$fatal(1, "Value check failed");
		end
	endtask

	// Step one clock at a time until ack, sampled 1 ns after the edge
	task automatic waitAck();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (!wbAck && cycles < ackTimeout);
		if (!wbAck) begin
			$display("Bus timeout: no ack within %0d cycles", ackTimeout);
			$display("*** TEST FAILED ***");
			$fatal(1, "Bus request never acknowledged");
		end
	endtask

	task automatic busWrite(input logic [2:0] adr, input logic [width-1:0] data);
		wbCyc  = 1'b1;
		wbStb  = 1'b1;
		wbWe   = 1'b1;
		wbAdr  = adr;
		wbDatW = data;
		waitAck();
		@(posedge clk);   // Write commits on this edge
		#1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe  = 1'b0;
	endtask

	task automatic busRead(input logic [2:0] adr, output logic [width-1:0] data);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe  = 1'b0;
		wbAdr = adr;
		waitAck();
		data = wbDatR;    // Valid for the whole ack cycle
		@(posedge clk);
		#1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
	endtask

	task automatic readCheck(input string name, input logic [2:0] adr,
			input logic [width-1:0] exp);
		logic [width-1:0] got;
		busRead(adr, got);
		checkValue(name, exp, got);
	endtask

	// Load operands, start the op, compare against the model
	task automatic runOp(input string name, input logic [1:0] op,
			input logic [width-1:0] a, input logic [width-1:0] b);
		logic [width+3:0] expd;
		busWrite(arithPkg::regOpA, a);
		busWrite(arithPkg::regOpB, b);
		busWrite(arithPkg::regCtrl, {30'b0, op});
		expd   = modelOp(op, a, b, mFlags[arithPkg::flagCarry]);
		mA     = a;
		mB     = b;
		mOp    = op;
		mRes   = expd[width-1:0];
		mFlags = {28'b0, expd[width+3:width]};
		readCheck({name, " result"}, arithPkg::regResult, mRes);
		readCheck({name, " flags"}, arithPkg::regFlags, mFlags);
		readCheck({name, " ctrl"}, arithPkg::regCtrl, {30'b0, mOp});
	endtask

	initial begin
		logic [width-1:0] a;
		logic [width-1:0] b;
		logic [width-1:0] junk;
		logic [1:0]       op;
		void'($urandom(32'h9bb1_f532));
		arstN  = 1'b0;
		wbCyc  = 1'b0;
		wbStb  = 1'b0;
		wbWe   = 1'b0;
		wbAdr  = '0;
		wbDatW = '0;
		mA     = '0;
		mB     = '0;
		mOp    = '0;
		mRes   = '0;
		mFlags = '0;
		repeat (4) @(posedge clk);
		#1;
		arstN = 1'b1;

		// Everything cleared by reset
		for (int i = 0; i < 8; i++) begin
			readCheck($sformatf("reset addr %0d", i), 3'(i), '0);
		end

		// Operand readback, read-only and unmapped addresses
		for (int i = 0; i < 20; i++) begin
			mA   = $urandom();
			mB   = $urandom();
			junk = $urandom();
			busWrite(arithPkg::regOpA, mA);
			busWrite(arithPkg::regOpB, mB);
			busWrite(arithPkg::regResult, junk);  // All three ignored
			busWrite(arithPkg::regFlags, junk);
			busWrite(3'(5 + i % 3), junk);
			readCheck("opA readback", arithPkg::regOpA, mA);
			readCheck("opB readback", arithPkg::regOpB, mB);
			readCheck("result untouched", arithPkg::regResult, '0);
			readCheck("flags untouched", arithPkg::regFlags, '0);
			readCheck("unmapped read", 3'(5 + i % 3), '0);
		end

		// Random operations, a third biased toward a zero sum
		for (int i = 0; i < numOps; i++) begin
			op = 2'($urandom_range(2, 0));
			a  = $urandom();
			b  = $urandom();
			if ($urandom_range(2, 0) == 0) begin
				if ($urandom_range(1, 0) == 0) b = a;   // Equal operands
				else b = -a;                            // Two's complement negative
			end
			runOp($sformatf("random op %0d", i), op, a, b);
		end

		// Zero only through wraparound, and near misses
		runOp("set carry", arithPkg::opAdd, 32'hffff_ffff, 32'h0000_0001);
		runOp("adc wrap", arithPkg::opAdc, 32'hffff_ffff, 32'h0000_0000);
		runOp("adc wrap swapped", arithPkg::opAdc, 32'h0000_0000, 32'hffff_ffff);
		runOp("adc one short", arithPkg::opAdc, 32'hffff_fffe, 32'h0000_0000);
		runOp("adc no carry", arithPkg::opAdc, 32'hffff_ffff, 32'h0000_0000);
		runOp("add all zero", arithPkg::opAdd, 32'h0000_0000, 32'h0000_0000);
		runOp("sub equal", arithPkg::opSub, 32'h0000_0001, 32'h0000_0001);
		runOp("sub one below", arithPkg::opSub, 32'h0000_0001, 32'h0000_0002);
		runOp("add min pair", arithPkg::opAdd, 32'h8000_0000, 32'h8000_0000);
		runOp("add neg pair", arithPkg::opAdd, 32'h7fff_ffff, 32'h8000_0001);
		runOp("add one short", arithPkg::opAdd, 32'h0000_0001, 32'hffff_fffe);

		// Held read: ack is a single-cycle pulse, never back to back
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe  = 1'b0;
		wbAdr = arithPkg::regOpA;
		waitAck();
		checkValue("ack data", mA, wbDatR);
		@(posedge clk);
		#1;
		checkValue("ack low after pulse", '0, {31'b0, wbAck});
		@(posedge clk);
		#1;
		checkValue("ack again while held", 32'd1, {31'b0, wbAck});
		checkValue("second ack data", mA, wbDatR);
		@(posedge clk);
		#1;
		checkValue("second ack one cycle", '0, {31'b0, wbAck});
		wbCyc = 1'b0;
		wbStb = 1'b0;

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- project.f
hdl/arithPkg.sv
hdl/aluIf.sv
hdl/SumZeroDet.sv
hdl/AddSub.sv
hdl/ArithRegs.sv
hdl/ArithTop.sv
dv/ArithTb.sv

//--- Makefile
.PHONY: help test clean

SOURCES = $(wildcard hdl/*.sv) dv/ArithTb.sv

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test: obj_dir/VArithTb
	./obj_dir/VArithTb

obj_dir/VArithTb: project.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps \
		--top-module ArithTb -f project.f -o VArithTb

clean:
	rm -rf obj_dir
